//--- hdl/burst_reader.sv
`timescale 1ns/1ps
`include "mem_fill_settings.svh"

module burst_reader (
    input  logic                clk,
    input  logic                rst,

    input  mem_fill_pkg::beat_t bmem_rdata_i,
    input  logic                bmem_rvalid_i,

    output mem_fill_pkg::line_t line_o,
    output logic                line_valid_o
);

    mem_fill_pkg::beat_cnt_t beat_cnt;
    logic                    last_beat;

    // slot of the next beat to arrive, wraps after the last one
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (bmem_rvalid_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign last_beat = (beat_cnt == mem_fill_pkg::beat_cnt_t'(`FILL_BEATS - 1));

    // line payload
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_o[beat_cnt * `FILL_BEAT_W +: `FILL_BEAT_W] <= bmem_rdata_i;
        end
    end

    // same cycle as the fourth beat, line_o complete on the next edge
    assign line_valid_o = bmem_rvalid_i && last_beat;

endmodule

//--- hdl/burst_writer.sv
`timescale 1ns/1ps
`include "mem_fill_settings.svh"

module burst_writer (
    input  logic                clk,
    input  logic                rst,

    input  logic                start_i,
    input  mem_fill_pkg::line_t line_i,

    input  logic                bmem_ready_i,
    output logic                bmem_write_o,
    output mem_fill_pkg::beat_t bmem_wdata_o,

    output logic                done_o
);

    mem_fill_pkg::line_t     line_q;
    mem_fill_pkg::beat_cnt_t beat_cnt;
    logic                    busy;
    logic                    last_beat;

    assign last_beat = (beat_cnt == mem_fill_pkg::beat_cnt_t'(`FILL_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;  // single cycle pulse
            if (start_i && !busy) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (busy && bmem_ready_i) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    // capture the writeback line once, client may move on after resp
    always_ff @(posedge clk) begin
        if (start_i && !busy) begin
            line_q <= line_i;
        end
    end

    assign bmem_write_o = busy;
    assign bmem_wdata_o = line_q[beat_cnt * `FILL_BEAT_W +: `FILL_BEAT_W];  // low beat first

endmodule

//--- hdl/fill_arbiter.sv
`timescale 1ns/1ps
`include "mem_fill_settings.svh"

module fill_arbiter (
    input  logic                     clk,
    input  logic                     rst,

    // fill clients
    input  mem_fill_pkg::line_req_t  i_req_i,
    input  mem_fill_pkg::line_req_t  d_req_i,
    output mem_fill_pkg::line_resp_t i_resp_o,
    output mem_fill_pkg::line_resp_t d_resp_o,

    // memory request side
    input  logic                     bmem_ready_i,
    output mem_fill_pkg::addr_t      bmem_addr_o,
    output logic                     bmem_read_o,

    // from the burst reader
    input  mem_fill_pkg::line_t      line_i,
    input  logic                     line_valid_i,

    // to and from the burst writer
    output logic                     wr_start_o,
    output mem_fill_pkg::line_t      wr_line_o,
    input  logic                     wr_done_i
);

    mem_fill_pkg::fill_state_e state;
    mem_fill_pkg::fill_state_e state_next;
    logic                      grant_d;       // 1 = data port owns the memory
    logic                      grant_d_next;
    logic                      d_pending;
    mem_fill_pkg::addr_t       req_addr;

    assign d_pending = d_req_i.read || d_req_i.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= mem_fill_pkg::IDLE;
            grant_d <= 1'b0;
        end else begin
            state   <= state_next;
            grant_d <= grant_d_next;
        end
    end

    always_comb begin
        state_next   = state;
        grant_d_next = grant_d;
        wr_start_o   = 1'b0;
        bmem_read_o  = 1'b0;

        unique case (state)
            mem_fill_pkg::IDLE: begin
                // data port first, instruction port waits its turn
                if (d_pending) begin
                    grant_d_next = 1'b1;
                    if (d_req_i.write) begin
                        wr_start_o = 1'b1;
                        state_next = mem_fill_pkg::WRITE;
                    end else begin
                        state_next = mem_fill_pkg::READ_REQ;
                    end
                end else if (i_req_i.read) begin
                    grant_d_next = 1'b0;
                    state_next   = mem_fill_pkg::READ_REQ;
                end
            end

            mem_fill_pkg::READ_REQ: begin
                bmem_read_o = 1'b1;  // held until memory takes it
                if (bmem_ready_i) begin
                    state_next = mem_fill_pkg::READ_WAIT;
                end
            end

            mem_fill_pkg::READ_WAIT: begin
                if (line_valid_i) begin
                    state_next = mem_fill_pkg::RESPOND;
                end
            end

            mem_fill_pkg::WRITE: begin
                // writer handles ready per beat
                if (wr_done_i) begin
                    state_next = mem_fill_pkg::RESPOND;
                end
            end

            mem_fill_pkg::RESPOND: begin
                state_next = mem_fill_pkg::IDLE;
            end

            default: begin
                state_next = mem_fill_pkg::IDLE;
            end
        endcase
    end

    // address of whoever holds the grant, forced to a line boundary
    assign req_addr    = grant_d ? d_req_i.addr : i_req_i.addr;
    assign bmem_addr_o = {req_addr[`FILL_ADDR_W-1:`FILL_OFFSET_BITS],
                          {`FILL_OFFSET_BITS{1'b0}}};

    assign wr_line_o = d_req_i.wdata;

    // reader holds the full line through RESPOND
    assign i_resp_o.rdata = line_i;
    assign d_resp_o.rdata = line_i;
    assign i_resp_o.resp  = (state == mem_fill_pkg::RESPOND) && !grant_d;
    assign d_resp_o.resp  = (state == mem_fill_pkg::RESPOND) && grant_d;

endmodule

//--- hdl/mem_fill_pkg.sv
`include "mem_fill_settings.svh"

package mem_fill_pkg;

    typedef logic [`FILL_ADDR_W-1:0]         addr_t;
    typedef logic [`FILL_BEAT_W-1:0]         beat_t;
    typedef logic [`FILL_LINE_W-1:0]         line_t;  // beat 0 in the low bits
    typedef logic [$clog2(`FILL_BEATS)-1:0]  beat_cnt_t;

    // line request from a fill client, held until resp
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } line_req_t;

    // rdata only valid while resp is high
    typedef struct packed {
        line_t rdata;
        logic  resp;
    } line_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,   // read held until memory ready
        READ_WAIT,  // beats coming back
        WRITE,      // writer busy with the line
        RESPOND     // one cycle resp pulse
    } fill_state_e;

endpackage

//--- hdl/mem_fill_settings.svh
`ifndef MEM_FILL_SETTINGS_SVH
`define MEM_FILL_SETTINGS_SVH

// byte address into the burst memory
`define FILL_ADDR_W 32

// one burst beat on the memory bus
`define FILL_BEAT_W 64

// one cache line, filled or written back as a unit
`define FILL_LINE_W 256

// beats per line (line width / beat width)
`define FILL_BEATS 4

// low address bits that are zero in a line address
`define FILL_OFFSET_BITS 5

`endif

//--- hdl/mem_fill_top.sv
`timescale 1ns/1ps

module mem_fill_top (
    input  logic                     clk,
    input  logic                     rst,

    // line clients
    input  mem_fill_pkg::line_req_t  i_req_i,
    input  mem_fill_pkg::line_req_t  d_req_i,
    output mem_fill_pkg::line_resp_t i_resp_o,
    output mem_fill_pkg::line_resp_t d_resp_o,

    // burst memory
    output mem_fill_pkg::addr_t      bmem_addr_o,
    output logic                     bmem_read_o,
    output logic                     bmem_write_o,
    output mem_fill_pkg::beat_t      bmem_wdata_o,
    input  logic                     bmem_ready_i,
    input  mem_fill_pkg::beat_t      bmem_rdata_i,
    input  logic                     bmem_rvalid_i
);

    mem_fill_pkg::line_t rd_line;
    logic                rd_line_valid;
    logic                wr_start;
    mem_fill_pkg::line_t wr_line;
    logic                wr_done;

    // read beats into a line
    burst_reader u_reader (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (rd_line),
        .line_valid_o  (rd_line_valid)
    );

    // writeback line out as beats
    burst_writer u_writer (
        .clk          (clk),
        .rst          (rst),
        .start_i      (wr_start),
        .line_i       (wr_line),
        .bmem_ready_i (bmem_ready_i),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .done_o       (wr_done)
    );

    fill_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_req_i      (i_req_i),
        .d_req_i      (d_req_i),
        .i_resp_o     (i_resp_o),
        .d_resp_o     (d_resp_o),
        .bmem_ready_i (bmem_ready_i),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .line_i       (rd_line),
        .line_valid_i (rd_line_valid),
        .wr_start_o   (wr_start),
        .wr_line_o    (wr_line),
        .wr_done_i    (wr_done)
    );

endmodule

//--- mem_fill_top.f
+incdir+hdl
hdl/mem_fill_pkg.sv
hdl/burst_reader.sv
hdl/burst_writer.sv
hdl/fill_arbiter.sv
hdl/mem_fill_top.sv
tb/mem_fill_assert.sv
tb/mem_fill_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f mem_fill_top.f \
    --top-module mem_fill_tb -o mem_fill_sim &&
./obj_dir/mem_fill_sim ||
{ echo "simulation run did not complete cleanly"; exit 1; }

//--- tb/mem_fill_assert.sv
`timescale 1ns/1ps

module mem_fill_assert (
    input logic                     clk,
    input logic                     rst,
    input mem_fill_pkg::line_resp_t i_resp_i,
    input mem_fill_pkg::line_resp_t d_resp_i,
    input mem_fill_pkg::addr_t      bmem_addr_i,
    input logic                     bmem_read_i,
    input logic                     bmem_write_i,
    input mem_fill_pkg::beat_t      bmem_wdata_i,
    input logic                     bmem_ready_i
);

    logic i_resp_bit;
    logic d_resp_bit;

    assign i_resp_bit = i_resp_i.resp;
    assign d_resp_bit = d_resp_i.resp;

    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_i && bmem_write_i))
        else $error("memory read and write requested together");

    // stalled read keeps its request and address
    read_held: assert property (@(posedge clk) disable iff (rst)
        (bmem_read_i && !bmem_ready_i) |=> (bmem_read_i && $stable(bmem_addr_i)))
        else $error("read request dropped or changed while stalled");

    write_held: assert property (@(posedge clk) disable iff (rst)
        (bmem_write_i && !bmem_ready_i) |=>
            (bmem_write_i && $stable(bmem_addr_i) && $stable(bmem_wdata_i)))
        else $error("write beat dropped or changed while stalled");

    i_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        i_resp_bit |=> !i_resp_bit)
        else $error("instruction response longer than one cycle");

    d_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        d_resp_bit |=> !d_resp_bit)
        else $error("data response longer than one cycle");

endmodule

bind mem_fill_top mem_fill_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .i_resp_i     (i_resp_o),
    .d_resp_i     (d_resp_o),
    .bmem_addr_i  (bmem_addr_o),
    .bmem_read_i  (bmem_read_o),
    .bmem_write_i (bmem_write_o),
    .bmem_wdata_i (bmem_wdata_o),
    .bmem_ready_i (bmem_ready_i)
);

//--- tb/mem_fill_tb.sv
`timescale 1ns/1ps
`include "mem_fill_settings.svh"

module mem_fill_tb;

    localparam logic [31:0] SEED         = 32'hd409_f736;
    localparam int          RESP_TIMEOUT = 200;
    localparam int          MIXED_OPS    = 150;  // per client

    // one memory transaction as the memory saw it
    typedef struct packed {
        logic                write;
        mem_fill_pkg::addr_t addr;
    } mem_txn_t;

    logic                     clk;
    logic                     rst;
    mem_fill_pkg::line_req_t  i_req;
    mem_fill_pkg::line_req_t  d_req;
    mem_fill_pkg::line_resp_t i_resp_o;
    mem_fill_pkg::line_resp_t d_resp_o;
    mem_fill_pkg::addr_t      bmem_addr_o;
    logic                     bmem_read_o;
    logic                     bmem_write_o;
    mem_fill_pkg::beat_t      bmem_wdata_o;
    logic                     bmem_ready  = 1'b0;
    mem_fill_pkg::beat_t      bmem_rdata  = '0;
    logic                     bmem_rvalid = 1'b0;

    mem_fill_pkg::line_t mem_lines [mem_fill_pkg::addr_t];
    mem_fill_pkg::line_t model_lines [mem_fill_pkg::addr_t];
    mem_txn_t            mem_log [$];

    logic [31:0]         i_st;
    logic [31:0]         d_st;
    logic [31:0]         mem_st = SEED ^ 32'h3c6e_f372;
    int                  i_issued;
    int                  d_issued;
    int                  i_resp_cnt = 0;
    int                  d_resp_cnt = 0;

    // memory side state
    logic                rd_active = 1'b0;
    int                  rd_delay;
    int                  rd_beat;
    mem_fill_pkg::line_t rd_line;
    int                  wr_cnt = 0;
    mem_fill_pkg::addr_t wr_addr;
    mem_fill_pkg::line_t wr_buf;

    mem_fill_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .i_req_i       (i_req),
        .d_req_i       (d_req),
        .i_resp_o      (i_resp_o),
        .d_resp_o      (d_resp_o),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_write_o  (bmem_write_o),
        .bmem_wdata_o  (bmem_wdata_o),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic mem_fill_pkg::line_t random_line(inout logic [31:0] st);
        mem_fill_pkg::line_t l;
        int                  k;
        for (k = 0; k < 8; k++) begin
            st = lcg_next(st);
            l[k*32 +: 32] = st;
        end
        return l;
    endfunction

    // untouched line contents, seeded by the whole address
    function automatic mem_fill_pkg::line_t fresh_line(input mem_fill_pkg::addr_t addr);
        logic [31:0] st;
        st = SEED ^ addr;
        return random_line(st);
    endfunction

    function automatic mem_fill_pkg::addr_t line_addr(input logic [3:0] idx);
        return 32'h2000_0000 + (mem_fill_pkg::addr_t'(idx) * 32'h0000_0460);
    endfunction

    function automatic mem_fill_pkg::line_t model_line(input mem_fill_pkg::addr_t addr);
        if (model_lines.exists(addr)) begin
            return model_lines[addr];
        end
        return fresh_line(addr);
    endfunction

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_line(input mem_fill_pkg::line_t got, input mem_fill_pkg::line_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input mem_fill_pkg::addr_t got, input mem_fill_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // behavioral burst memory, samples the DUT on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            bmem_rvalid <= 1'b0;
            bmem_ready  <= 1'b0;
            rd_active   = 1'b0;
            wr_cnt      = 0;
        end else begin
            mem_st = lcg_next(mem_st);
            bmem_ready  <= (mem_st[31:30] != 2'b00);  // drops about a quarter
            bmem_rvalid <= 1'b0;
            bmem_rdata  <= {mem_st, ~mem_st};          // junk between beats

            if (bmem_read_o && bmem_ready) begin
                if (rd_active) begin
                    report_problem("a second read was accepted while one was in flight");
                end
                if (!mem_lines.exists(bmem_addr_o)) begin
                    mem_lines[bmem_addr_o] = fresh_line(bmem_addr_o);
                end
                rd_line   = mem_lines[bmem_addr_o];
                rd_active = 1'b1;
                rd_beat   = 0;
                rd_delay  = 1 + (mem_st[15:8] % 6);
                mem_log.push_back({1'b0, bmem_addr_o});
            end else if (rd_active) begin
                if (rd_delay > 0) begin
                    rd_delay = rd_delay - 1;
                end else if (mem_st[7:6] != 2'b00) begin  // random gaps
                    bmem_rvalid <= 1'b1;
                    bmem_rdata  <= rd_line[rd_beat*`FILL_BEAT_W +: `FILL_BEAT_W];
                    rd_beat = rd_beat + 1;
                    if (rd_beat == `FILL_BEATS) begin
                        rd_active = 1'b0;
                    end
                end
            end

            if (bmem_write_o && bmem_ready) begin
                if (wr_cnt == 0) begin
                    wr_addr = bmem_addr_o;
                    mem_log.push_back({1'b1, bmem_addr_o});
                end else begin
                    check_addr(bmem_addr_o, wr_addr, "write beat address");
                end
                wr_buf[wr_cnt*`FILL_BEAT_W +: `FILL_BEAT_W] = bmem_wdata_o;
                wr_cnt = wr_cnt + 1;
                if (wr_cnt == `FILL_BEATS) begin
                    mem_lines[wr_addr] = wr_buf;
                    wr_cnt = 0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (i_resp_o.resp && d_resp_o.resp) begin
                report_problem("both response bits were high in the same cycle");
            end
            if (i_resp_o.resp) begin
                i_resp_cnt = i_resp_cnt + 1;
            end
            if (d_resp_o.resp) begin
                d_resp_cnt = d_resp_cnt + 1;
            end
        end
    end

    task automatic i_read(input mem_fill_pkg::addr_t addr);
        mem_fill_pkg::line_req_t req;
        mem_txn_t                txn;
        int                      cyc;
        logic                    got;
        req      = '0;
        req.addr = addr;
        req.read = 1'b1;
        @(posedge clk);
        i_req <= req;
        i_issued = i_issued + 1;
        got = 1'b0;
        cyc = 0;
        while (!got && cyc < RESP_TIMEOUT) begin
            @(posedge clk);
            cyc = cyc + 1;
            got = i_resp_o.resp;
        end
        if (!got) begin
            report_problem("instruction port got no response within 200 cycles");
        end
        check_line(i_resp_o.rdata, model_line(addr), "instruction fill data");
        txn = mem_log[$];  // served transaction is the newest one
        check_bit(txn.write, 1'b0, "instruction fill memory transaction is a write");
        check_addr(txn.addr, addr, "instruction fill memory address");
        i_req <= '0;
    endtask

    task automatic d_access(input logic is_write, input mem_fill_pkg::addr_t addr,
                            input mem_fill_pkg::line_t wdata);
        mem_fill_pkg::line_req_t req;
        mem_txn_t                txn;
        int                      cyc;
        logic                    got;
        req.addr  = addr;
        req.read  = !is_write;
        req.write = is_write;
        req.wdata = wdata;
        @(posedge clk);
        d_req <= req;
        d_issued = d_issued + 1;
        got = 1'b0;
        cyc = 0;
        while (!got && cyc < RESP_TIMEOUT) begin
            @(posedge clk);
            cyc = cyc + 1;
            got = d_resp_o.resp;
        end
        if (!got) begin
            report_problem("data port got no response within 200 cycles");
        end
        txn = mem_log[$];
        check_bit(txn.write, is_write, "data port memory transaction kind");
        check_addr(txn.addr, addr, "data port memory address");
        if (is_write) begin
            check_line(mem_lines[addr], wdata, "line assembled by memory from write beats");
            model_lines[addr] = wdata;
        end else begin
            check_line(d_resp_o.rdata, model_line(addr), "data fill data");
        end
        d_req <= '0;
    endtask

    initial begin
        mem_fill_pkg::addr_t a;
        mem_fill_pkg::addr_t b;
        mem_fill_pkg::line_t w;
        int                  base;
        int                  k;

        rst      = 1'b1;
        i_req    = '0;
        d_req    = '0;
        i_st     = SEED;
        d_st     = lcg_next(SEED ^ 32'h9e37_79b9);
        i_issued = 0;
        d_issued = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // idle after reset
        for (k = 0; k < 8; k++) begin
            @(posedge clk);
            check_bit(bmem_read_o, 1'b0, "bmem_read_o while idle");
            check_bit(bmem_write_o, 1'b0, "bmem_write_o while idle");
            check_bit(i_resp_o.resp, 1'b0, "instruction resp while idle");
            check_bit(d_resp_o.resp, 1'b0, "data resp while idle");
        end

        for (k = 0; k < 4; k++) begin
            i_st = lcg_next(i_st);
            i_read(line_addr(i_st[27:24]));
        end

        // writeback then read back through both ports
        for (k = 0; k < 4; k++) begin
            d_st = lcg_next(d_st);
            a = line_addr(d_st[27:24]);
            w = random_line(d_st);
            d_access(1'b1, a, w);
            d_access(1'b0, a, '0);
            i_read(a);
        end

        // same cycle requests, data goes first
        for (k = 0; k < 2; k++) begin
            d_st = lcg_next(d_st);
            a = line_addr(d_st[27:24]);
            b = line_addr(d_st[27:24] ^ 4'h5);
            w = random_line(d_st);
            base = mem_log.size();
            fork
                d_access(k == 0, a, w);
                i_read(b);
            join
            check_bit(mem_log[base].write, k == 0, "first transaction kind");
            check_addr(mem_log[base].addr, a, "first transaction is the data request");
            check_bit(mem_log[base+1].write, 1'b0, "second transaction kind");
            check_addr(mem_log[base+1].addr, b, "second transaction is the instruction read");
        end

        // both clients running freely
        fork
            begin
                repeat (MIXED_OPS) begin
                    i_st = lcg_next(i_st);
                    i_read(line_addr(i_st[27:24]));
                    i_st = lcg_next(i_st);
                    repeat (i_st[17:16]) @(posedge clk);
                end
            end
            begin
                repeat (MIXED_OPS) begin
                    w = random_line(d_st);
                    d_st = lcg_next(d_st);
                    d_access(d_st[31], line_addr(d_st[27:24]), w);
                    d_st = lcg_next(d_st);
                    repeat (d_st[17:16]) @(posedge clk);
                end
            end
        join

        repeat (5) @(posedge clk);  // let the resp counters catch up
        if (i_resp_cnt != i_issued || d_resp_cnt != d_issued) begin
            report_problem("number of responses differs from number of requests");
        end else if (mem_log.size() != i_issued + d_issued) begin
            report_problem("number of memory transactions differs from number of requests");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule
